// File: lat_stimulus.txt
# Columns: D = cycles from transmit strobe to receive strobe (decimal),
#          expected latency count read back from STATUS and LAST.
1 1
2 2
3 3
5 5
8 8
13 13
21 21
34 34
55 55
89 89
144 144
177 177
200 200
233 233
250 250
254 254

// File: sim.f
+incdir+.
lat_pkg.sv
lat_resync.sv
lat_measure.sv
lat_stats.sv
lat_csr.sv
lat_top.sv
tb_lat_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the latency probe testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f \
        --top-module tb_lat_top -o tb_lat_top; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_lat_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$sim_out"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: tb_lat_top.sv
/* Testbench for the latency probe: file-driven and random measurements,
   a model of the statistics and register map checks. */
`timescale 1ns/1ns
`include "lat_params.svh"

module tb_lat_top
    import lat_pkg::*;
();

    localparam logic [`LAT_ADDR_W-1:0] A_CTRL   = 4'd0;
    localparam logic [`LAT_ADDR_W-1:0] A_STATUS = 4'd1;
    localparam logic [`LAT_ADDR_W-1:0] A_LAST   = 4'd2;
    localparam logic [`LAT_ADDR_W-1:0] A_MIN    = 4'd3;
    localparam logic [`LAT_ADDR_W-1:0] A_MAX    = 4'd4;
    localparam logic [`LAT_ADDR_W-1:0] A_NUM    = 4'd5;

    logic                   i_clk_pll;
    logic                   rst;
    csr_req_t               csr_req;
    logic                   tx_sop;
    logic                   rx_sop;
    logic [`LAT_DATA_W-1:0] rdata;
    logic                   rvalid;
    int                     errors;
    int                     test_start_errors;
    int                     n_pass;
    int                     n_fail;
    int                     exp_min;
    int                     exp_max;
    int                     exp_num;

    lat_top i_dut (
        .i_clk_pll    (i_clk_pll),
        .rst          (rst),
        .i_csr_req    (csr_req),
        .i_tx_lat_sop (tx_sop),
        .i_rx_lat_sop (rx_sop),
        .o_csr_rdata  (rdata),
        .o_csr_rvalid (rvalid)
    );

    always #2 i_clk_pll = ~i_clk_pll;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // STATUS layout: done in bit 0, count in bits 15:8.
    function automatic logic [31:0] status_word(input logic done, input int cnt);
        logic [31:0] w;
        w       = '0;
        w[0]    = done;
        w[15:8] = cnt[7:0];
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic report_failure(input string why);
        $display("ERROR: %s", why);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge i_clk_pll);
        #1; // Drive point after the edge.
    endtask

    task automatic reg_write(input logic [`LAT_ADDR_W-1:0] addr, input logic [31:0] data);
        csr_req.wr    = 1'b1;
        csr_req.addr  = addr;
        csr_req.wdata = data;
        next_cycle();
        csr_req = '0;
    endtask

    task automatic reg_read(input logic [`LAT_ADDR_W-1:0] addr, output logic [31:0] data);
        int waited;
        waited       = 0;
        csr_req.rd   = 1'b1;
        csr_req.addr = addr;
        next_cycle();
        csr_req.rd = 1'b0;
        while (!rvalid && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (!rvalid) begin
            report_failure("no read valid seen after a register read");
        end
        data = rdata;
        next_cycle();
        check_value("o_csr_rvalid", 32'd0, {31'd0, rvalid}); // Valid lasts one cycle.
    endtask

    task automatic expect_reg(input string name, input logic [`LAT_ADDR_W-1:0] addr,
                              input logic [31:0] exp_val);
        logic [31:0] value;
        reg_read(addr, value);
        check_value({"o_csr_rdata ", name}, exp_val, value);
    endtask

    task automatic run_measure(input int d, input bit extra_tx, output logic [31:0] status);
        int polls;
        reg_write(A_CTRL, 32'h2); // Measurement clear, probe off.
        reg_write(A_CTRL, 32'h1);
        tx_sop = 1'b1;
        for (int i = 1; i <= d; i++) begin
            next_cycle();
            tx_sop = extra_tx && (d >= 4) && (i == d / 2); // Optional second strobe.
        end
        rx_sop = 1'b1;
        next_cycle();
        rx_sop = 1'b0;
        polls  = 0;
        status = '0;
        while (!status[0] && polls < 64) begin
            reg_read(A_STATUS, status);
            polls++;
        end
        if (!status[0]) begin
            report_failure("done never set while polling STATUS");
        end
    endtask

    task automatic idle_strobes(input bit with_tx);
        if (with_tx) begin
            tx_sop = 1'b1;
            next_cycle();
            tx_sop = 1'b0;
            repeat (4) next_cycle();
        end
        rx_sop = 1'b1;
        next_cycle();
        rx_sop = 1'b0;
        repeat (20) next_cycle();
    endtask

    task automatic record_result(input int cnt);
        exp_min = (cnt < exp_min) ? cnt : exp_min;
        exp_max = (cnt > exp_max) ? cnt : exp_max;
        exp_num++;
    endtask

    task automatic check_stats();
        expect_reg("MIN", A_MIN, exp_min);
        expect_reg("MAX", A_MAX, exp_max);
        expect_reg("NUM", A_NUM, exp_num);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic measure_test(input int d, input int exp_cnt, input bit extra_tx,
                                input string label);
        logic [31:0] status;
        begin_test();
        run_measure(d, extra_tx, status);
        check_value("o_csr_rdata STATUS", status_word(1'b1, exp_cnt), status);
        expect_reg("LAST", A_LAST, exp_cnt);
        record_result(exp_cnt);
        finish_test($sformatf("%s D=%0d", label, d));
    endtask

    initial begin
        int          fd;
        int          code;
        int          d;
        int          exp_cnt;
        int          n_lines;
        logic [31:0] rng;
        string       line;
        i_clk_pll = 1'b0;
        rst       = 1'b1;
        csr_req   = '0;
        tx_sop    = 1'b0;
        rx_sop    = 1'b0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        n_lines   = 0;
        exp_min   = 255;
        exp_max   = 0;
        exp_num   = 0;
        rng       = 32'd89;
        repeat (3) @(posedge i_clk_pll);
        #1;
        rst = 1'b0;

        begin_test();
        expect_reg("CTRL", A_CTRL, 32'd0);
        expect_reg("STATUS", A_STATUS, 32'd0);
        expect_reg("LAST", A_LAST, 32'd0);
        expect_reg("MAX", A_MAX, 32'd0);
        expect_reg("NUM", A_NUM, 32'd0);
        reg_write(A_CTRL, 32'h4);
        expect_reg("MIN", A_MIN, 32'd255);
        finish_test("reset values");

        fd = $fopen("lat_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open lat_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%d %d", d, exp_cnt);
                    if (code == 2) begin
                        measure_test(d, exp_cnt, 1'b0, "file");
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            report_failure("lat_stimulus.txt holds no measurement lines");
        end

        begin_test();
        check_stats();
        finish_test("statistics after file");

        begin_test();
        reg_write(A_CTRL, 32'h2);
        expect_reg("STATUS", A_STATUS, 32'd0);
        check_stats();
        finish_test("measurement clear");

        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            d   = int'(rng % 32'd200) + 1;
            measure_test(d, d, 1'b0, "random");
        end
        measure_test(40, 40, 1'b1, "second transmit");

        begin_test();
        check_stats();
        finish_test("statistics after random");

        // A receive strobe alone starts no measurement.
        begin_test();
        reg_write(A_CTRL, 32'h2);
        reg_write(A_CTRL, 32'h1);
        idle_strobes(1'b0);
        expect_reg("STATUS", A_STATUS, 32'd0);
        check_stats();
        finish_test("receive only");

        begin_test();
        reg_write(A_CTRL, 32'h2);
        idle_strobes(1'b1);
        expect_reg("STATUS", A_STATUS, 32'd0);
        check_stats();
        finish_test("probe disabled");

        begin_test();
        reg_write(A_CTRL, 32'h4);
        exp_min = 255;
        exp_max = 0;
        exp_num = 0;
        expect_reg("LAST", A_LAST, 32'd0);
        check_stats();
        finish_test("statistics clear");

        begin_test();
        expect_reg("addr 6", 4'd6, 32'd0);
        expect_reg("addr 15", 4'd15, 32'd0);
        finish_test("unmapped read");

        $display("tests: %0d ok, %0d failing, %0d check errors", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: lat_top.sv
/* Latency probe top: register file, measurement block and statistics. */
`timescale 1ns/1ns
`include "lat_params.svh"

module lat_top
    import lat_pkg::*;
(
    input  logic                   i_clk_pll,
    input  logic                   rst,
    input  csr_req_t               i_csr_req,
    input  logic                   i_tx_lat_sop,
    input  logic                   i_rx_lat_sop,
    output logic [`LAT_DATA_W-1:0] o_csr_rdata,
    output logic                   o_csr_rvalid
);

    lat_ctrl_t             ctrl;
    logic                  lat_done;
    logic [`LAT_CNT_W-1:0] lat_cnt;
    lat_stats_t            stats;

    lat_csr u_csr (
        .i_clk_pll    (i_clk_pll),
        .rst          (rst),
        .i_csr_req    (i_csr_req),
        .i_lat_done   (lat_done),
        .i_lat_cnt    (lat_cnt),
        .i_stats      (stats),
        .o_ctrl       (ctrl),
        .o_csr_rdata  (o_csr_rdata),
        .o_csr_rvalid (o_csr_rvalid)
    );

    lat_measure u_measure (
        .i_clk_pll    (i_clk_pll),
        .rst          (rst),
        .i_ctrl       (ctrl),
        .i_tx_lat_sop (i_tx_lat_sop),
        .i_rx_lat_sop (i_rx_lat_sop),
        .o_lat_done   (lat_done),
        .o_lat_cnt    (lat_cnt)
    );

    lat_stats u_stats (
        .i_clk_pll   (i_clk_pll),
        .rst         (rst),
        .i_stats_clr (ctrl.stats_clr),
        .i_lat_done  (lat_done),
        .i_lat_cnt   (lat_cnt),
        .o_stats     (stats)
    );

endmodule

// File: lat_csr.sv
/* Probe register file: control bit and clear pulses, status and
   statistics readback with a one-cycle read-valid. */
`timescale 1ns/1ns
`include "lat_params.svh"

module lat_csr
    import lat_pkg::*;
(
    input  logic                   i_clk_pll,
    input  logic                   rst,
    input  csr_req_t               i_csr_req,
    input  logic                   i_lat_done,
    input  logic [`LAT_CNT_W-1:0]  i_lat_cnt,
    input  lat_stats_t             i_stats,
    output lat_ctrl_t              o_ctrl,
    output logic [`LAT_DATA_W-1:0] o_csr_rdata,
    output logic                   o_csr_rvalid
);

    localparam logic [`LAT_ADDR_W-1:0] ADDR_CTRL   = 'd0;
    localparam logic [`LAT_ADDR_W-1:0] ADDR_STATUS = 'd1;
    localparam logic [`LAT_ADDR_W-1:0] ADDR_LAST   = 'd2;
    localparam logic [`LAT_ADDR_W-1:0] ADDR_MIN    = 'd3;
    localparam logic [`LAT_ADDR_W-1:0] ADDR_MAX    = 'd4;
    localparam logic [`LAT_ADDR_W-1:0] ADDR_NUM    = 'd5;

    logic                   en_r;
    logic                   ctrl_wr;
    logic [`LAT_DATA_W-1:0] rd_mux;
    logic [`LAT_DATA_W-1:0] rdata_r;
    logic                   rvalid_r;

    assign ctrl_wr = i_csr_req.wr && (i_csr_req.addr == ADDR_CTRL);

    always_ff @(posedge i_clk_pll) begin
        if (rst) begin
            en_r <= 1'b0;
        end else if (ctrl_wr) begin
            en_r <= i_csr_req.wdata[0];
        end
    end

    // Clear pulses act on the edge that samples the write.
    assign o_ctrl.en        = en_r;
    assign o_ctrl.meas_clr  = ctrl_wr && i_csr_req.wdata[1];
    assign o_ctrl.stats_clr = ctrl_wr && i_csr_req.wdata[2];

    always_comb begin
        rd_mux = '0;
        case (i_csr_req.addr)
            ADDR_CTRL: begin
                rd_mux[0] = en_r; // Clear bits read as 0.
            end
            ADDR_STATUS: begin
                rd_mux[0]               = i_lat_done;
                rd_mux[8 +: `LAT_CNT_W] = i_lat_cnt;
            end
            ADDR_LAST: rd_mux[`LAT_CNT_W-1:0] = i_stats.last;
            ADDR_MIN:  rd_mux[`LAT_CNT_W-1:0] = i_stats.min_lat;
            ADDR_MAX:  rd_mux[`LAT_CNT_W-1:0] = i_stats.max_lat;
            ADDR_NUM:  rd_mux[`LAT_NUM_W-1:0] = i_stats.num;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk_pll) begin
        if (rst) begin
            rvalid_r <= 1'b0;
        end else begin
            rvalid_r <= i_csr_req.rd;
        end
    end

    always_ff @(posedge i_clk_pll) begin
        if (i_csr_req.rd) begin
            rdata_r <= rd_mux;
        end
    end

    assign o_csr_rdata  = rdata_r;
    assign o_csr_rvalid = rvalid_r;

endmodule

// File: lat_stats.sv
/* Latency statistics: last, minimum and maximum value and the number of
   finished measurements. */
`timescale 1ns/1ns
`include "lat_params.svh"

module lat_stats
    import lat_pkg::*;
(
    input  logic                  i_clk_pll,
    input  logic                  rst,
    input  logic                  i_stats_clr,
    input  logic                  i_lat_done,
    input  logic [`LAT_CNT_W-1:0] i_lat_cnt,
    output lat_stats_t            o_stats
);

    logic       done_d;
    logic       done_rise;
    lat_stats_t stats_r;

    always_ff @(posedge i_clk_pll) begin
        if (rst) begin
            done_d <= 1'b0;
        end else begin
            done_d <= i_lat_done;
        end
    end

    assign done_rise = i_lat_done && !done_d;

    always_ff @(posedge i_clk_pll) begin
        if (rst || i_stats_clr) begin
            stats_r.last    <= '0;
            stats_r.min_lat <= '1; // Any first result is smaller.
            stats_r.max_lat <= '0;
            stats_r.num     <= '0;
        end else if (done_rise) begin
            stats_r.last <= i_lat_cnt;
            if (i_lat_cnt < stats_r.min_lat) begin
                stats_r.min_lat <= i_lat_cnt;
            end
            if (i_lat_cnt > stats_r.max_lat) begin
                stats_r.max_lat <= i_lat_cnt;
            end
            if (stats_r.num != '1) begin
                stats_r.num <= stats_r.num + 1'b1; // Saturates.
            end
        end
    end

    assign o_stats = stats_r;

endmodule

// File: lat_measure.sv
/* Start-of-packet latency counter: latches the transmit and receive
   strobes and counts the clock cycles between them. */
`timescale 1ns/1ns
`include "lat_params.svh"

module lat_measure
    import lat_pkg::*;
(
    input  logic                  i_clk_pll,
    input  logic                  rst,
    input  lat_ctrl_t             i_ctrl,
    input  logic                  i_tx_lat_sop,
    input  logic                  i_rx_lat_sop,
    output logic                  o_lat_done,
    output logic [`LAT_CNT_W-1:0] o_lat_cnt
);

    logic                  tx_sop_sync;
    logic                  rx_sop_sync;
    logic                  clr;
    logic                  tx_lat;
    logic                  rx_lat;
    logic                  rx_lat_d;
    logic                  cnt_en;
    logic                  done_r;
    logic [`LAT_CNT_W-1:0] cnt_r;

    lat_resync #(
        .WIDTH  (2),
        .STAGES (`LAT_SYNC_STAGES)
    ) u_sop_sync (
        .i_clk_pll (i_clk_pll),
        .rst       (rst),
        .i_d       ({i_tx_lat_sop, i_rx_lat_sop}),
        .o_q       ({tx_sop_sync, rx_sop_sync})
    );

    assign clr = rst | i_ctrl.meas_clr;

    // Latches hold the first strobe seen while enabled.
    always_ff @(posedge i_clk_pll) begin
        if (clr || !i_ctrl.en) begin
            tx_lat <= 1'b0;
            rx_lat <= 1'b0;
        end else begin
            if (tx_sop_sync) begin
                tx_lat <= 1'b1;
            end
            if (rx_sop_sync && tx_lat) begin
                rx_lat <= 1'b1; // Only after a transmit strobe.
            end
        end
    end

    always_ff @(posedge i_clk_pll) begin
        if (clr) begin
            rx_lat_d <= 1'b0;
        end else begin
            rx_lat_d <= rx_lat;
        end
    end

    always_ff @(posedge i_clk_pll) begin
        if (clr || rx_lat) begin
            cnt_en <= 1'b0; // Stops once the receive latch is set.
        end else if (tx_lat) begin
            cnt_en <= 1'b1;
        end
    end

    always_ff @(posedge i_clk_pll) begin
        if (clr) begin
            done_r <= 1'b0;
        end else if (rx_lat && !rx_lat_d) begin
            done_r <= 1'b1; // Sticky until the next clear.
        end
    end

    always_ff @(posedge i_clk_pll) begin
        if (clr) begin
            cnt_r <= '0;
        end else if (cnt_en) begin
            cnt_r <= cnt_r + 1'b1;
        end
    end

    assign o_lat_done = done_r;
    assign o_lat_cnt  = cnt_r;

endmodule

// File: lat_resync.sv
/* Multi-stage flip-flop synchronizer for a bundle of strobes. */
`timescale 1ns/1ns

module lat_resync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 3
) (
    input  logic             i_clk_pll,
    input  logic             rst,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q
);

    logic [WIDTH-1:0] sync_r [STAGES];

    always_ff @(posedge i_clk_pll) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_r[i] <= '0;
            end
        end else begin
            sync_r[0] <= i_d; // First stage may go metastable.
            for (int i = 1; i < STAGES; i++) begin
                sync_r[i] <= sync_r[i-1];
            end
        end
    end

    assign o_q = sync_r[STAGES-1];

endmodule

// File: lat_pkg.sv
/* Types shared by the latency probe: register request, control outputs
   of the register file and the statistics bundle. */
`include "lat_params.svh"

package lat_pkg;

    // One host register access.
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`LAT_ADDR_W-1:0] addr;
        logic [`LAT_DATA_W-1:0] wdata;
    } csr_req_t;

    // Enable is a level, the clears are single-cycle pulses.
    typedef struct packed {
        logic en;
        logic meas_clr;
        logic stats_clr;
    } lat_ctrl_t;

    typedef struct packed {
        logic [`LAT_CNT_W-1:0] last;
        logic [`LAT_CNT_W-1:0] min_lat;
        logic [`LAT_CNT_W-1:0] max_lat;
        logic [`LAT_NUM_W-1:0] num;
    } lat_stats_t;

endpackage

// File: lat_params.svh
/* Sizing macros for the MAC latency probe: synchronizer depth, counter
   widths and register bus widths. */
`ifndef LAT_PARAMS_SVH
`define LAT_PARAMS_SVH

// Flip-flops in the strobe synchronizer.
`define LAT_SYNC_STAGES 3

// Latency counter, wraps at this width.
`define LAT_CNT_W 8

// Register bus.
`define LAT_ADDR_W 4
`define LAT_DATA_W 32

// Finished-measurement counter.
`define LAT_NUM_W 16

`endif
